// ==== design/adc_pkg.sv ====
package adc_pkg;

	// analog inputs on the converter mux
	localparam int NUM_CH = 8;

	typedef logic [NUM_CH-1:0] chan_sel_t;

	// input i is reported as code i+1, zero means no channel
	typedef logic [3:0] chan_code_t;

	typedef logic [9:0] sample_t;

	typedef logic [15:0] level_t;

	typedef enum logic [1:0] {
		mode_single      = 2'd0,
		mode_sequential  = 2'd1,
		mode_scan_once   = 2'd2,
		mode_scan_repeat = 2'd3
	} adc_mode_e;

	typedef enum logic [2:0] {
		st_idle      = 3'd0,
		st_convert   = 3'd1,
		st_settle    = 3'd2,
		st_hold_wait = 3'd3,
		st_advance   = 3'd4
	} seq_state_e;

	typedef struct packed {
		adc_mode_e mode;
		chan_sel_t in_en;
		level_t    round_num;
	} adc_cfg_t;

	typedef struct packed {
		chan_code_t chan;
		sample_t    data;
	} fifo_word_t;

endpackage

// ==== design/adc_edge_sync.sv ====
`timescale 1ns/1ps

module adc_edge_sync (
	input  logic clk_32m,
	input  logic rstb,
	input  logic adc_start_req,
	input  logic adc_ckout,
	output logic start_level,
	output logic start_rise,
	output logic ckout_fall
);

	// bit 1 is the start request, bit 0 the converter clock-out
	logic [1:0] sync_0;
	logic [1:0] sync_1;
	logic [1:0] sync_d;

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			sync_0 <= '0;
			sync_1 <= '0;
			sync_d <= '0;
		end
		else
		begin
			sync_0 <= {adc_start_req, adc_ckout};
			sync_1 <= sync_0;
			sync_d <= sync_1;
		end
	end

	assign start_level = sync_1[1];
	assign start_rise  = sync_1[1] & ~sync_d[1];
	// end of conversion, result is valid here
	assign ckout_fall  = ~sync_1[0] & sync_d[0];

endmodule

// ==== design/adc_seq_fsm.sv ====
`timescale 1ns/1ps

module adc_seq_fsm #(
	parameter int SETTLE_CYCLES = 4
) (
	input  logic             clk_32m,
	input  logic             rstb,
	input  adc_pkg::adc_cfg_t cfg,
	input  logic             start_rise,
	input  logic             start_level,
	input  logic             ckout_fall,
	input  logic             full,
	input  logic             round_done,
	output logic             adc_start,
	output logic             sample_wr,
	output logic             load_first,
	output logic             step_next
);

	localparam int CW = $clog2(SETTLE_CYCLES + 1);

	adc_pkg::seq_state_e state;
	adc_pkg::seq_state_e state_nxt;
	logic [CW-1:0]       settle_cnt;
	adc_pkg::level_t     sample_cnt;
	adc_pkg::level_t     round_cnt;
	adc_pkg::level_t     round_target;
	logic                settle_last;
	logic                scan_mode;
	logic                more;

	assign settle_last = (settle_cnt == CW'(SETTLE_CYCLES - 1));
	assign scan_mode   = (cfg.mode == adc_pkg::mode_scan_once) ||
	                     (cfg.mode == adc_pkg::mode_scan_repeat);
	// zero rounds still runs one
	assign round_target = (cfg.round_num == '0) ? 16'd1 : cfg.round_num;

	assign adc_start  = (state == adc_pkg::st_convert);
	assign sample_wr  = (state == adc_pkg::st_convert) && ckout_fall && !full;
	assign load_first = (state == adc_pkg::st_idle) && start_rise && !full;
	// selection moves during settle so advance sees the new channel
	assign step_next  = (state == adc_pkg::st_settle) && settle_last && scan_mode;

	always_comb
	begin
		more = 1'b0;
		case (cfg.mode)
			adc_pkg::mode_single:      more = 1'b0;
			adc_pkg::mode_sequential:  more = (cfg.round_num == '0) ||
			                                  (sample_cnt < cfg.round_num);
			adc_pkg::mode_scan_once:   more = !round_done;
			adc_pkg::mode_scan_repeat: more = !round_done ||
			                                  (round_cnt < round_target - 16'd1);
			default:                   more = 1'b0;
		endcase
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			adc_pkg::st_idle:      if (load_first) state_nxt = adc_pkg::st_convert;
			adc_pkg::st_convert:   if (ckout_fall) state_nxt = adc_pkg::st_settle;
			adc_pkg::st_settle:    if (settle_last) state_nxt = adc_pkg::st_advance;
			adc_pkg::st_advance:
			begin
				if (!more)
					state_nxt = adc_pkg::st_idle;
				else if (full)
					state_nxt = adc_pkg::st_hold_wait;
				else
					state_nxt = adc_pkg::st_convert;
			end
			adc_pkg::st_hold_wait: if (!full) state_nxt = adc_pkg::st_convert;
			default:               state_nxt = adc_pkg::st_idle;
		endcase
		// request dropped, abort the run
		if (state != adc_pkg::st_idle && !start_level)
			state_nxt = adc_pkg::st_idle;
	end

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			state      <= adc_pkg::st_idle;
			settle_cnt <= '0;
			sample_cnt <= '0;
			round_cnt  <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (state == adc_pkg::st_settle && !settle_last)
				settle_cnt <= settle_cnt + 1'b1;
			else
				settle_cnt <= '0;
			if (state == adc_pkg::st_idle)
				sample_cnt <= '0;
			else if (sample_wr)
				sample_cnt <= sample_cnt + 16'd1;
			if (state == adc_pkg::st_idle)
				round_cnt <= '0;
			else if (state == adc_pkg::st_advance && round_done &&
			         cfg.mode == adc_pkg::mode_scan_repeat)
				round_cnt <= round_cnt + 16'd1;
		end
	end

	// end of conversion always finds room for its word
	a_wr_not_full: assert property (@(posedge clk_32m) disable iff (!rstb)
		(state == adc_pkg::st_convert && ckout_fall) |-> !full);

	// a run only starts from a request edge
	a_idle_no_start: assert property (@(posedge clk_32m) disable iff (!rstb)
		(state == adc_pkg::st_idle && !start_rise) |=> !adc_start);

endmodule

// ==== design/adc_chan_scan.sv ====
`timescale 1ns/1ps

module adc_chan_scan (
	input  logic                clk_32m,
	input  logic                rstb,
	input  adc_pkg::chan_sel_t  in_en,
	input  logic                load_first,
	input  logic                step_next,
	output adc_pkg::chan_sel_t  adc_in_sel,
	output adc_pkg::chan_code_t chan_code,
	output logic                round_done
);

	adc_pkg::chan_sel_t first_sel;
	int                 step_start;

	// first enabled input at or below start, wrapping past zero
	function automatic adc_pkg::chan_sel_t pick_down(input int start,
		input adc_pkg::chan_sel_t en);
		adc_pkg::chan_sel_t sel;
		logic               found;
		int                 pos;
		sel   = '0;
		found = 1'b0;
		for (int k = 0; k < adc_pkg::NUM_CH; k++)
		begin
			pos = (start + adc_pkg::NUM_CH - k) % adc_pkg::NUM_CH;
			if (!found && en[pos])
			begin
				sel[pos] = 1'b1;
				found    = 1'b1;
			end
		end
		return sel;
	endfunction

	always_comb
	begin
		chan_code = '0;
		for (int i = 0; i < adc_pkg::NUM_CH; i++)
			if (adc_in_sel[i])
				chan_code = adc_pkg::chan_code_t'(i + 1);
	end

	// search starts one input below the current one
	always_comb
	begin
		if (chan_code == '0)
			step_start = adc_pkg::NUM_CH - 1;
		else
			step_start = (int'(chan_code) + adc_pkg::NUM_CH - 2) % adc_pkg::NUM_CH;
	end

	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			adc_in_sel <= '0;
			first_sel  <= '0;
		end
		else if (load_first)
		begin
			adc_in_sel <= pick_down(adc_pkg::NUM_CH - 1, in_en);
			first_sel  <= pick_down(adc_pkg::NUM_CH - 1, in_en);
		end
		else if (step_next)
			adc_in_sel <= pick_down(step_start, in_en);
	end

	assign round_done = (adc_in_sel == first_sel) && (adc_in_sel != '0);

	a_sel_onehot: assert property (@(posedge clk_32m) disable iff (!rstb)
		$onehot0(adc_in_sel));

endmodule

// ==== design/adc_sample_fifo.sv ====
`timescale 1ns/1ps

module adc_sample_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                clk_32m,
	input  logic                rstb,
	input  logic                wr_en,
	input  adc_pkg::fifo_word_t wr_data,
	input  logic                rd_en,
	output adc_pkg::fifo_word_t rd_data,
	output logic                rd_valid,
	output logic                empty,
	output logic                full,
	output adc_pkg::level_t     fill_level,
	input  adc_pkg::level_t     half_level,
	input  adc_pkg::level_t     full_level,
	output logic                half_irq,
	output logic                full_irq
);

	localparam int AW = $clog2(FIFO_DEPTH);

	adc_pkg::fifo_word_t mem [FIFO_DEPTH];
	logic [AW-1:0]       wr_ptr;
	logic [AW-1:0]       rd_ptr;
	adc_pkg::level_t     count_nxt;
	logic                do_wr;
	logic                do_rd;

	assign empty = (fill_level == '0);
	assign full  = (fill_level == adc_pkg::level_t'(FIFO_DEPTH));
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_comb
	begin
		case ({do_wr, do_rd})
			2'b10:   count_nxt = fill_level + 16'd1;
			2'b01:   count_nxt = fill_level - 16'd1;
			default: count_nxt = fill_level;
		endcase
	end

	always_ff @(posedge clk_32m)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill_level <= '0;
			rd_valid   <= 1'b0;
			half_irq   <= 1'b0;
			full_irq   <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			fill_level <= count_nxt;
			rd_valid   <= do_rd;
			// thresholds track the new level in the same cycle
			half_irq   <= (count_nxt >= half_level);
			full_irq   <= (count_nxt >= full_level);
		end
	end

	a_level_bound: assert property (@(posedge clk_32m) disable iff (!rstb)
		fill_level <= adc_pkg::level_t'(FIFO_DEPTH));

endmodule

// ==== design/adc_control_top.sv ====
`timescale 1ns/1ps

module adc_control_top #(
	parameter int FIFO_DEPTH    = 16,
	parameter int SETTLE_CYCLES = 4
) (
	input  logic                clk_32m,
	input  logic                rstb,
	input  logic                adc_start_req,
	input  adc_pkg::adc_cfg_t   cfg,
	input  adc_pkg::level_t     half_level,
	input  adc_pkg::level_t     full_level,
	input  logic                adc_ckout,
	input  adc_pkg::sample_t    adc_dout,
	input  logic                rd_en,
	output logic                adc_start,
	output adc_pkg::chan_sel_t  adc_in_sel,
	output adc_pkg::fifo_word_t rd_data,
	output logic                rd_valid,
	output logic                empty,
	output logic                full,
	output adc_pkg::level_t     fill_level,
	output logic                half_irq,
	output logic                full_irq
);

	logic                start_level;
	logic                start_rise;
	logic                ckout_fall;
	logic                sample_wr;
	logic                load_first;
	logic                step_next;
	logic                round_done;
	adc_pkg::chan_code_t chan_code;
	adc_pkg::fifo_word_t wr_word;

	// channel code in the upper bits, result below
	assign wr_word.chan = chan_code;
	assign wr_word.data = adc_dout;

	adc_edge_sync u_edge_sync (
		.clk_32m(clk_32m), .rstb(rstb),
		.adc_start_req(adc_start_req), .adc_ckout(adc_ckout),
		.start_level(start_level), .start_rise(start_rise), .ckout_fall(ckout_fall)
	);

	adc_seq_fsm #(.SETTLE_CYCLES(SETTLE_CYCLES)) u_seq_fsm (
		.clk_32m(clk_32m), .rstb(rstb), .cfg(cfg),
		.start_rise(start_rise), .start_level(start_level), .ckout_fall(ckout_fall),
		.full(full), .round_done(round_done), .adc_start(adc_start),
		.sample_wr(sample_wr), .load_first(load_first), .step_next(step_next)
	);

	adc_chan_scan u_chan_scan (
		.clk_32m(clk_32m), .rstb(rstb), .in_en(cfg.in_en),
		.load_first(load_first), .step_next(step_next), .adc_in_sel(adc_in_sel),
		.chan_code(chan_code), .round_done(round_done)
	);

	adc_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_sample_fifo (
		.clk_32m(clk_32m), .rstb(rstb), .wr_en(sample_wr), .wr_data(wr_word),
		.rd_en(rd_en), .rd_data(rd_data), .rd_valid(rd_valid), .empty(empty),
		.full(full), .fill_level(fill_level), .half_level(half_level),
		.full_level(full_level), .half_irq(half_irq), .full_irq(full_irq)
	);

endmodule

// ==== verif/adc_checker.sv ====
`timescale 1ns/1ps

module adc_checker #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                clk_32m,
	input  logic                rstb,
	input  logic                adc_start_req,
	input  adc_pkg::adc_cfg_t   cfg,
	input  adc_pkg::level_t     half_level,
	input  adc_pkg::level_t     full_level,
	input  logic                adc_ckout,
	input  adc_pkg::sample_t    adc_dout,
	input  logic                adc_start,
	input  adc_pkg::chan_sel_t  adc_in_sel,
	input  adc_pkg::fifo_word_t rd_data,
	input  logic                rd_valid,
	input  logic                empty,
	input  logic                full,
	input  adc_pkg::level_t     fill_level,
	input  logic                half_irq,
	input  logic                full_irq,
	input  logic                done,
	output logic                run_open,
	output int                  mismatch_cnt,
	output int                  fault_cnt
);

	adc_pkg::fifo_word_t exp_word[$];
	adc_pkg::fifo_word_t w;
	int                  exp_chan[$];
	int                  unb_chan;
	int                  cur_chan;
	int                  lvl;
	logic                unbounded;
	logic                req_d;
	logic                start_d;
	logic                ck_d;
	logic                full_d;
	logic                rst_seen;
	// converter fall to fill_level change, through the synchronizer
	logic [2:0]          wr_pipe;

	task automatic flag_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		mismatch_cnt++;
	endtask

	task automatic log_fault(input string msg);
		$display("error at %0t: %s", $time, msg);
		fault_cnt++;
	endtask

	// expected channel sequence of one run
	task automatic build_run();
		int order[$];
		int rounds;
		for (int i = adc_pkg::NUM_CH - 1; i >= 0; i--)
			if (cfg.in_en[i])
				order.push_back(i);
		exp_chan.delete();
		unbounded = 1'b0;
		rounds = (cfg.round_num == '0) ? 1 : int'(cfg.round_num);
		case (cfg.mode)
			adc_pkg::mode_single:
				exp_chan.push_back(order[0]);
			adc_pkg::mode_sequential:
			begin
				unb_chan  = order[0];
				unbounded = (cfg.round_num == '0);
				repeat (cfg.round_num)
					exp_chan.push_back(order[0]);
			end
			default:
			begin
				if (cfg.mode == adc_pkg::mode_scan_once)
					rounds = 1;
				repeat (rounds)
					foreach (order[k])
						exp_chan.push_back(order[k]);
			end
		endcase
	endtask

	always @(posedge clk_32m or negedge rstb)
	begin
		if (!rstb)
		begin
			exp_word.delete();
			exp_chan.delete();
			unbounded = 1'b0;
			lvl       = 0;
			req_d    <= 1'b0;
			start_d  <= 1'b0;
			ck_d     <= 1'b0;
			full_d   <= 1'b0;
			rst_seen <= 1'b0;
			wr_pipe  <= '0;
			run_open <= 1'b0;
		end
		else
		begin
			if (!rst_seen)
			begin
				if (adc_start || rd_valid || half_irq || full_irq || !empty ||
				    adc_in_sel != '0 || fill_level != '0)
					log_fault("outputs not at their reset values after reset");
				rst_seen <= 1'b1;
			end

			if (adc_start_req && !req_d)
				build_run();
			if (!adc_start_req && req_d)
			begin
				exp_chan.delete();
				unbounded = 1'b0;
			end

			if (adc_start && !start_d)
			begin
				if (full_d)
					log_fault("conversion started while the FIFO was full");
				if (!unbounded && exp_chan.size() == 0)
					log_fault("conversion started outside a run");
				else
				begin
					cur_chan = unbounded ? unb_chan : exp_chan.pop_front();
					if (adc_in_sel !== (adc_pkg::chan_sel_t'(1) << cur_chan))
						flag_mismatch($sformatf("input select %b, expected input %0d",
							adc_in_sel, cur_chan));
				end
			end

			// result taken at the converter falling edge
			if (ck_d && !adc_ckout)
			begin
				w.chan = adc_pkg::chan_code_t'(cur_chan + 1);
				w.data = adc_dout;
				exp_word.push_back(w);
			end

			if (rd_valid)
			begin
				if (exp_word.size() == 0)
					log_fault("read data appeared with no word expected");
				else
				begin
					w = exp_word.pop_front();
					if (rd_data !== w)
						flag_mismatch($sformatf("read chan %0d data %0h, expected chan %0d data %0h",
							rd_data.chan, rd_data.data, w.chan, w.data));
				end
			end

			lvl = lvl + int'(wr_pipe[2]) - int'(rd_valid);
			if (fill_level !== adc_pkg::level_t'(lvl))
				flag_mismatch($sformatf("fill level %0d, expected %0d", fill_level, lvl));
			if (empty !== (lvl == 0) || full !== (lvl == FIFO_DEPTH))
				flag_mismatch($sformatf("empty %b full %b at level %0d", empty, full, lvl));
			if (half_irq !== (lvl >= int'(half_level)) || full_irq !== (lvl >= int'(full_level)))
				flag_mismatch($sformatf("half_irq %b full_irq %b at level %0d",
					half_irq, full_irq, lvl));

			if (done && exp_word.size() != 0)
				log_fault($sformatf("%0d words were written but never read", exp_word.size()));

			req_d    <= adc_start_req;
			start_d  <= adc_start;
			ck_d     <= adc_ckout;
			full_d   <= full;
			wr_pipe  <= {wr_pipe[1:0], ck_d && !adc_ckout};
			run_open <= unbounded || (exp_chan.size() != 0);
		end
	end

endmodule

// ==== verif/tb_adc_control.sv ====
`timescale 1ns/1ps

module tb_adc_control;

	localparam int FIFO_DEPTH    = 16;
	localparam int SETTLE_CYCLES = 4;
	localparam int NUM_TESTS     = 24;
	localparam int CYCLE_LIMIT   = 2000 * NUM_TESTS;

	logic                clk_32m;
	logic                rstb;
	logic                adc_start_req;
	adc_pkg::adc_cfg_t   cfg;
	adc_pkg::level_t     half_level;
	adc_pkg::level_t     full_level;
	logic                adc_ckout;
	adc_pkg::sample_t    adc_dout;
	logic                rd_en = 1'b0;
	logic                adc_start;
	adc_pkg::chan_sel_t  adc_in_sel;
	adc_pkg::fifo_word_t rd_data;
	logic                rd_valid;
	logic                empty;
	logic                full;
	adc_pkg::level_t     fill_level;
	logic                half_irq;
	logic                full_irq;
	logic                rd_on;
	logic                done;
	logic                run_open;
	int                  mismatch_cnt;
	int                  fault_cnt;
	int                  cycle_cnt = 0;
	int unsigned         seed_out;

	adc_control_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) u_adc_control_top (.*);

	adc_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_checker (.*);

	initial
	begin
		clk_32m = 1'b0;
		forever
			#2 clk_32m = ~clk_32m;
	end

	always @(posedge clk_32m)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	always @(posedge clk_32m)
	begin
		if (rstb)
			rd_en <= rd_on && ($urandom % 3 == 0);
	end

	// converter model, one result per adc_start
	initial
	begin : converter
		int wait_cyc;
		adc_ckout = 1'b0;
		adc_dout  = '0;
		forever
		begin
			@(posedge clk_32m);
			if (adc_start)
			begin
				wait_cyc = 3 + int'($urandom % 8);
				repeat (wait_cyc) @(posedge clk_32m);
				adc_dout  <= adc_pkg::sample_t'($urandom);
				adc_ckout <= 1'b1;
				repeat (2) @(posedge clk_32m);
				adc_ckout <= 1'b0;
				while (adc_start)
					@(posedge clk_32m);
			end
		end
	end

	task automatic wait_conversion_end();
		while (!adc_start)
			@(posedge clk_32m);
		while (adc_start)
			@(posedge clk_32m);
	endtask

	initial
	begin : stimulus
		adc_pkg::adc_cfg_t cfg_v;
		int                n_conv;
		logic              stall;
		seed_out      = $urandom(32'h2ecb);
		rstb          = 1'b0;
		adc_start_req = 1'b0;
		cfg           = '0;
		rd_on         = 1'b1;
		done          = 1'b0;
		half_level    = adc_pkg::level_t'(4 + $urandom % 5);
		full_level    = adc_pkg::level_t'(12 + $urandom % 5);
		repeat (2) @(posedge clk_32m);
		rstb <= 1'b1;
		repeat (4) @(posedge clk_32m);

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			cfg_v.mode      = adc_pkg::adc_mode_e'(2'($urandom));
			cfg_v.in_en     = adc_pkg::chan_sel_t'(1 + $urandom % 255);
			cfg_v.round_num = adc_pkg::level_t'($urandom % 4);
			// withheld reads, an endless run fills the FIFO
			stall = (t % 6 == 5);
			if (stall)
			begin
				cfg_v.mode      = adc_pkg::mode_sequential;
				cfg_v.round_num = '0;
			end
			while (full)
				@(posedge clk_32m);
			cfg   <= cfg_v;
			rd_on <= !stall;
			@(posedge clk_32m);
			adc_start_req <= 1'b1;
			repeat (2) @(posedge clk_32m);
			if (cfg_v.mode == adc_pkg::mode_sequential && cfg_v.round_num == '0)
			begin
				if (stall)
				begin
					while (!full)
						@(posedge clk_32m);
					repeat (40) @(posedge clk_32m);
					rd_on <= 1'b1;
				end
				// drop right after a word is written
				n_conv = 2 + int'($urandom % 4);
				repeat (n_conv) wait_conversion_end();
			end
			else
			begin
				while (run_open)
					@(posedge clk_32m);
				wait_conversion_end();
				repeat (SETTLE_CYCLES + 10) @(posedge clk_32m);
			end
			adc_start_req <= 1'b0;
			repeat (8 + $urandom % 8) @(posedge clk_32m);
		end

		rd_on <= 1'b1;
		while (!empty)
			@(posedge clk_32m);
		repeat (5) @(posedge clk_32m);
		done <= 1'b1;
		@(posedge clk_32m);
		done <= 1'b0;
		repeat (2) @(posedge clk_32m);
		$display("closing report: %0d mismatches, %0d other errors", mismatch_cnt, fault_cnt);
		if (mismatch_cnt == 0 && fault_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/adc_pkg.sv
design/adc_edge_sync.sv
design/adc_seq_fsm.sv
design/adc_chan_scan.sv
design/adc_sample_fifo.sv
design/adc_control_top.sv
verif/adc_checker.sv
verif/tb_adc_control.sv

// ==== run.sh ====
#!/bin/sh
# build the ADC controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_adc_control -f verilog.f -o tb_adc_control
then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/tb_adc_control 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1
